// File: verilog/ice_pkg.sv
package ice_pkg;

	// Stream and register widths
	localparam int BYTE_W = 8;
	localparam int GPIO_W = 24;
	localparam int PARAM_W = 24;

	// Reset values of the I2C settings
	localparam logic [BYTE_W-1:0] I2C_SPEED_RST = 8'h63;
	localparam logic [2*BYTE_W-1:0] I2C_ADDR_RST = 16'hFFFF;

	// Host command bytes, ASCII
	typedef enum logic [BYTE_W-1:0] {
		CMD_VERSION    = 8'h76,
		CMD_QUERY_I2C  = 8'h49,
		CMD_SET_I2C    = 8'h69,
		CMD_QUERY_GPIO = 8'h47,
		CMD_SET_GPIO   = 8'h67
	} cmd_e;

	// Register targets picked by the selector byte
	// Selector chars: c, a for I2C and l, d, i for GPIO
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_I2C_SPEED,
		SEL_I2C_ADDR,
		SEL_GPIO_LEVEL,
		SEL_GPIO_DIR,
		SEL_GPIO_INT
	} param_sel_e;

	// First byte of every response
	typedef enum logic [BYTE_W-1:0] {
		RESP_ACK = 8'h00,
		RESP_NAK = 8'h01
	} resp_code_e;

endpackage

// File: verilog/frame_rx.sv
module frame_rx import ice_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [BYTE_W-1:0] in_data,
	input  logic              in_valid,
	input  logic              in_frame,
	output cmd_e              cmd,
	output logic              cmd_valid,
	output logic [BYTE_W-1:0] eid,
	output logic [BYTE_W-1:0] pay_data,
	output logic              pay_valid,
	output logic              frame_end
);

	// Header positions: 0 command, 1 event ID, 2 length, 3 payload
	logic       frame_q;
	logic [1:0] pos;
	logic [1:0] cur_pos;
	logic       frame_start;
	logic       take;

	assign frame_start = in_frame && !frame_q;
	// First byte may arrive in the same cycle the frame opens
	assign cur_pos = frame_start ? 2'd0 : pos;
	assign take = in_valid && in_frame;

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_q <= 1'b0;
			pos <= 2'd0;
			cmd_valid <= 1'b0;
			pay_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			frame_q <= in_frame;
			frame_end <= frame_q && !in_frame;
			cmd_valid <= take && (cur_pos == 2'd0);
			pay_valid <= take && (cur_pos == 2'd3);
			// Stays on payload until the next frame starts
			if (take && (cur_pos != 2'd3)) begin
				pos <= cur_pos + 2'd1;
			end else if (frame_start) begin
				pos <= 2'd0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pay_data <= in_data;
			if (cur_pos == 2'd0) begin
				cmd <= cmd_e'(in_data);
			end
			// Held for the response of this frame
			if (cur_pos == 2'd1) begin
				eid <= in_data;
			end
		end
	end

endmodule

// File: verilog/cmd_ctrl.sv
module cmd_ctrl import ice_pkg::*; #(
	parameter logic [BYTE_W-1:0] VERSION_MAJOR = 8'h00,
	parameter logic [BYTE_W-1:0] VERSION_MINOR = 8'h04
) (
	input  logic               clk,
	input  logic               rst,
	input  cmd_e               cmd,
	input  logic               cmd_valid,
	input  logic [BYTE_W-1:0]  pay_data,
	input  logic               pay_valid,
	input  logic               frame_end,
	output param_sel_e         wr_sel,
	output logic [BYTE_W-1:0]  wr_data,
	output logic               wr_valid,
	output logic               commit,
	output param_sel_e         rd_sel,
	input  logic [PARAM_W-1:0] rd_word,
	output logic               start,
	output resp_code_e         code,
	output logic [PARAM_W-1:0] data_word,
	output logic [1:0]         data_count,
	input  logic               resp_last
);

	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		VERSION_IN,
		WRITE,
		RESPOND,
		WAIT_RESP,
		COMMIT
	} state_e;

	localparam logic [PARAM_W-1:0] VERSION_WORD =
		{{(PARAM_W-2*BYTE_W){1'b0}}, VERSION_MAJOR, VERSION_MINOR};

	state_e              state;
	cmd_e                cmd_q;
	param_sel_e          sel_q;
	param_sel_e          dec_sel;
	logic [1:0]          dec_len;
	logic [1:0]          len_q;
	logic [1:0]          cnt;
	logic                nak_q;
	logic [2*BYTE_W-1:0] version_in;
	logic                is_query;
	logic                is_gpio_set;

	assign is_query = (cmd_q == CMD_QUERY_I2C) || (cmd_q == CMD_QUERY_GPIO);
	assign is_gpio_set = (cmd_q == CMD_SET_GPIO) && !nak_q;

	// Selector byte to target and byte count, per command family
	always_comb begin
		dec_sel = SEL_NONE;
		dec_len = 2'd0;
		case (cmd_q)
			CMD_QUERY_I2C, CMD_SET_I2C: begin
				if (pay_data == "c") begin
					dec_sel = SEL_I2C_SPEED;
					dec_len = 2'd1;
				end else if (pay_data == "a") begin
					dec_sel = SEL_I2C_ADDR;
					dec_len = 2'd2;
				end
			end
			CMD_QUERY_GPIO, CMD_SET_GPIO: begin
				dec_len = 2'd3;
				if (pay_data == "l") begin
					dec_sel = SEL_GPIO_LEVEL;
				end else if (pay_data == "d") begin
					dec_sel = SEL_GPIO_DIR;
				end else if (pay_data == "i") begin
					dec_sel = SEL_GPIO_INT;
				end
			end
			default: begin
				dec_sel = SEL_NONE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			sel_q <= SEL_NONE;
			nak_q <= 1'b0;
			cnt <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_valid) begin
						nak_q <= 1'b0;
						cnt <= 2'd0;
						state <= (cmd == CMD_VERSION) ? VERSION_IN : SELECT;
					end
				end
				SELECT: begin
					if (frame_end) begin
						state <= IDLE;
					end else if (pay_valid) begin
						sel_q <= dec_sel;
						// Unknown command ends up here too
						if (dec_sel == SEL_NONE) begin
							nak_q <= 1'b1;
							state <= RESPOND;
						end else if (is_query) begin
							state <= RESPOND;
						end else begin
							state <= WRITE;
						end
					end
				end
				VERSION_IN: begin
					if (frame_end) begin
						state <= IDLE;
					end else if (pay_valid) begin
						cnt <= cnt + 2'd1;
						if (cnt == 2'd1) begin
							state <= RESPOND;
						end
					end
				end
				WRITE: begin
					if (frame_end) begin
						state <= IDLE;
					end else if (pay_valid) begin
						cnt <= cnt + 2'd1;
						if (cnt + 2'd1 == len_q) begin
							state <= RESPOND;
						end
					end
				end
				RESPOND: begin
					state <= WAIT_RESP;
				end
				WAIT_RESP: begin
					// GPIO values go live only once the ACK is out
					if (resp_last) begin
						state <= is_gpio_set ? COMMIT : IDLE;
					end
				end
				COMMIT: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid) begin
			cmd_q <= cmd;
		end
		if (state == SELECT && pay_valid) begin
			len_q <= dec_len;
		end
		if (state == VERSION_IN && pay_valid) begin
			version_in <= {version_in[BYTE_W-1:0], pay_data};
		end
	end

	assign wr_sel = sel_q;
	assign rd_sel = sel_q;
	assign wr_data = pay_data;
	assign wr_valid = (state == WRITE) && pay_valid && !frame_end;
	assign commit = (state == COMMIT);

	// Response fields, sampled by resp_tx while start is high
	always_comb begin
		start = (state == RESPOND);
		code = RESP_ACK;
		data_word = rd_word;
		data_count = 2'd0;
		if (nak_q) begin
			code = RESP_NAK;
		end else if (cmd_q == CMD_VERSION) begin
			data_word = VERSION_WORD;
			if (version_in != {VERSION_MAJOR, VERSION_MINOR}) begin
				code = RESP_NAK;
				data_count = 2'd2;
			end
		end else if (is_query) begin
			data_count = len_q;
		end
	end

endmodule

// File: verilog/param_regs.sv
module param_regs import ice_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  param_sel_e          wr_sel,
	input  logic [BYTE_W-1:0]   wr_data,
	input  logic                wr_valid,
	input  logic                commit,
	input  param_sel_e          rd_sel,
	output logic [PARAM_W-1:0]  rd_word,
	input  logic [GPIO_W-1:0]   gpio_read,
	output logic [BYTE_W-1:0]   i2c_speed,
	output logic [2*BYTE_W-1:0] i2c_addr,
	output logic [GPIO_W-1:0]   gpio_level,
	output logic [GPIO_W-1:0]   gpio_direction,
	output logic [GPIO_W-1:0]   gpio_int_enable
);

	logic [GPIO_W-1:0] level_stage;
	logic [GPIO_W-1:0] dir_stage;
	logic [GPIO_W-1:0] int_stage;

	// Live registers
	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= I2C_SPEED_RST;
			i2c_addr <= I2C_ADDR_RST;
			gpio_level <= '0;
			gpio_direction <= '0;
			gpio_int_enable <= '0;
		end else begin
			// I2C bytes land straight in the live value
			if (wr_valid) begin
				case (wr_sel)
					SEL_I2C_SPEED: i2c_speed <= wr_data;
					SEL_I2C_ADDR: i2c_addr <= {i2c_addr[BYTE_W-1:0], wr_data};
					default: ;
				endcase
			end
			if (commit) begin
				case (wr_sel)
					SEL_GPIO_LEVEL: gpio_level <= level_stage;
					SEL_GPIO_DIR: gpio_direction <= dir_stage;
					SEL_GPIO_INT: gpio_int_enable <= int_stage;
					default: ;
				endcase
			end
		end
	end

	// GPIO staging, MSB first
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			case (wr_sel)
				SEL_GPIO_LEVEL: level_stage <= {level_stage[GPIO_W-BYTE_W-1:0], wr_data};
				SEL_GPIO_DIR: dir_stage <= {dir_stage[GPIO_W-BYTE_W-1:0], wr_data};
				SEL_GPIO_INT: int_stage <= {int_stage[GPIO_W-BYTE_W-1:0], wr_data};
				default: ;
			endcase
		end
	end

	// Right-aligned read word
	always_comb begin
		case (rd_sel)
			SEL_I2C_SPEED: rd_word = PARAM_W'(i2c_speed);
			SEL_I2C_ADDR: rd_word = PARAM_W'(i2c_addr);
			// Level query reports the sampled pins, not the output value
			SEL_GPIO_LEVEL: rd_word = PARAM_W'(gpio_read);
			SEL_GPIO_DIR: rd_word = PARAM_W'(gpio_direction);
			SEL_GPIO_INT: rd_word = PARAM_W'(gpio_int_enable);
			default: rd_word = '0;
		endcase
	end

endmodule

// File: verilog/resp_tx.sv
module resp_tx import ice_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  resp_code_e         code,
	input  logic [BYTE_W-1:0]  eid,
	input  logic [PARAM_W-1:0] data_word,
	input  logic [1:0]         data_count,
	output logic [BYTE_W-1:0]  resp_data,
	output logic               resp_valid,
	output logic               resp_last
);

	localparam int SH_W = 2*BYTE_W + PARAM_W;

	logic [SH_W-1:0]    shreg;
	logic [2:0]         remaining;
	logic [PARAM_W-1:0] aligned;

	// Move the used low bytes of data_word to the top
	assign aligned = data_word << (BYTE_W * (3 - int'(data_count)));

	always_ff @(posedge clk) begin
		if (rst) begin
			remaining <= 3'd0;
		end else if (start) begin
			remaining <= 3'd2 + {1'b0, data_count};
		end else if (remaining != 3'd0) begin
			remaining <= remaining - 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			shreg <= {code, eid, aligned};
		end else if (remaining != 3'd0) begin
			shreg <= shreg << BYTE_W;
		end
	end

	// One byte per cycle from the top of the shift register
	assign resp_data = shreg[SH_W-1 -: BYTE_W];
	assign resp_valid = (remaining != 3'd0);
	assign resp_last = (remaining == 3'd1);

endmodule

// File: verilog/ice_basics.sv
module ice_basics import ice_pkg::*; #(
	parameter logic [BYTE_W-1:0] VERSION_MAJOR = 8'h00,
	parameter logic [BYTE_W-1:0] VERSION_MINOR = 8'h04
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [BYTE_W-1:0]   in_data,
	input  logic                in_valid,
	input  logic                in_frame,
	input  logic [GPIO_W-1:0]   gpio_read,
	output logic [BYTE_W-1:0]   resp_data,
	output logic                resp_valid,
	output logic                resp_last,
	output logic [BYTE_W-1:0]   i2c_speed,
	output logic [2*BYTE_W-1:0] i2c_addr,
	output logic [GPIO_W-1:0]   gpio_level,
	output logic [GPIO_W-1:0]   gpio_direction,
	output logic [GPIO_W-1:0]   gpio_int_enable
);

	cmd_e               cmd;
	logic               cmd_valid;
	logic [BYTE_W-1:0]  eid;
	logic [BYTE_W-1:0]  pay_data;
	logic               pay_valid;
	logic               frame_end;
	param_sel_e         wr_sel;
	logic [BYTE_W-1:0]  wr_data;
	logic               wr_valid;
	logic               commit;
	param_sel_e         rd_sel;
	logic [PARAM_W-1:0] rd_word;
	logic               start;
	resp_code_e         code;
	logic [PARAM_W-1:0] data_word;
	logic [1:0]         data_count;

	frame_rx u_frame_rx (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_frame(in_frame),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.eid(eid),
		.pay_data(pay_data),
		.pay_valid(pay_valid),
		.frame_end(frame_end)
	);

	cmd_ctrl #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) u_cmd_ctrl (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.pay_data(pay_data),
		.pay_valid(pay_valid),
		.frame_end(frame_end),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.commit(commit),
		.rd_sel(rd_sel),
		.rd_word(rd_word),
		.start(start),
		.code(code),
		.data_word(data_word),
		.data_count(data_count),
		.resp_last(resp_last)
	);

	param_regs u_param_regs (
		.clk(clk),
		.rst(rst),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.commit(commit),
		.rd_sel(rd_sel),
		.rd_word(rd_word),
		.gpio_read(gpio_read),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	resp_tx u_resp_tx (
		.clk(clk),
		.rst(rst),
		.start(start),
		.code(code),
		.eid(eid),
		.data_word(data_word),
		.data_count(data_count),
		.resp_data(resp_data),
		.resp_valid(resp_valid),
		.resp_last(resp_last)
	);

endmodule

// File: verif/ice_model.svh
`ifndef ICE_MODEL_SVH
`define ICE_MODEL_SVH

// Version the handler reports by default
localparam logic [7:0] VER_MAJOR = 8'h00;
localparam logic [7:0] VER_MINOR = 8'h04;

// Expected register state, updated frame by frame
logic [7:0]  m_speed;
logic [15:0] m_addr;
logic [23:0] m_level;
logic [23:0] m_dir;
logic [23:0] m_int;

// Response bytes of the last modelled frame
logic [7:0]  m_resp [0:4];

function automatic void model_reset();
	m_speed = 8'h63;
	m_addr = 16'hFFFF;
	m_level = 24'h000000;
	m_dir = 24'h000000;
	m_int = 24'h000000;
endfunction

// Frame bytes right-aligned in fr, byte 0 is the command
// Returns the number of response bytes, 0 when the frame is dropped
function automatic int model_frame(input logic [63:0] fr, input int n, input logic [23:0] pins);
	logic [7:0]  f [0:7];
	logic [23:0] word;
	logic [23:0] value;
	int          len;
	int          i;
	bit          i2c;
	bit          query;
	for (i = 0; i < 8; i++) begin
		if (i < n) begin
			f[i] = fr[8*(n-1-i) +: 8];
		end else begin
			f[i] = 8'h00;
		end
	end
	m_resp[0] = 8'h00;
	m_resp[1] = f[1];
	// Nothing is decided before the first payload byte
	if (n < 4) begin
		return 0;
	end
	if (f[0] == 8'h76) begin
		if (n < 5) begin
			return 0;
		end
		if (f[3] == VER_MAJOR && f[4] == VER_MINOR) begin
			return 2;
		end
		m_resp[0] = 8'h01;
		m_resp[2] = VER_MAJOR;
		m_resp[3] = VER_MINOR;
		return 4;
	end
	i2c = (f[0] == 8'h49) || (f[0] == 8'h69);
	query = (f[0] == 8'h49) || (f[0] == 8'h47);
	len = 0;
	word = 24'h000000;
	if (i2c) begin
		if (f[3] == "c") begin
			len = 1;
			word = {16'h0000, m_speed};
		end else if (f[3] == "a") begin
			len = 2;
			word = {8'h00, m_addr};
		end
	end else if (f[0] == 8'h47 || f[0] == 8'h67) begin
		len = 3;
		if (f[3] == "l") begin
			word = pins;
		end else if (f[3] == "d") begin
			word = m_dir;
		end else if (f[3] == "i") begin
			word = m_int;
		end else begin
			len = 0;
		end
	end
	// Unknown command, or selector outside the command family
	if (len == 0) begin
		m_resp[0] = 8'h01;
		return 2;
	end
	if (query) begin
		for (i = 0; i < len; i++) begin
			m_resp[2+i] = word[8*(len-1-i) +: 8];
		end
		return 2 + len;
	end
	if (n < 4 + len) begin
		return 0;
	end
	value = {f[4], f[5], f[6]} >> (8 * (3 - len));
	if (i2c && f[3] == "c") begin
		m_speed = value[7:0];
	end else if (i2c) begin
		m_addr = value[15:0];
	end else if (f[3] == "l") begin
		m_level = value;
	end else if (f[3] == "d") begin
		m_dir = value;
	end else begin
		m_int = value;
	end
	return 2;
endfunction

`endif

// File: verif/tb_ice_basics.sv
module tb_ice_basics;
	timeunit 1ns;
	timeprecision 100ps;

	// Room for about 40 frames of about 25 cycles each three times over
	localparam int MAX_FRAMES = 40;
	localparam int FRAME_CYCLES = 25;
	localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES * 3;
	localparam int RESP_WAIT = 40;

	logic        clk;
	logic        rst;
	logic [7:0]  in_data;
	logic        in_valid;
	logic        in_frame;
	logic [23:0] gpio_read;
	logic [7:0]  resp_data;
	logic        resp_valid;
	logic        resp_last;
	logic [7:0]  i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;
	logic [23:0] gpio_int_enable;

	integer     seed;
	int         cycles = 0;
	int         errors;
	int         tests_run;
	int         tests_bad;
	int         test_err_base;
	string      test_name;
	int         sent_resp;
	int         checked;
	int         exp_len [$];
	logic [7:0] exp_data [$];
	int         got_len [$];
	logic [7:0] got_data [$];

	`include "ice_model.svh"

	ice_basics dut (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_frame(in_frame),
		.gpio_read(gpio_read),
		.resp_data(resp_data),
		.resp_valid(resp_valid),
		.resp_last(resp_last),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles in test %s", cycles, test_name);
		$display("*** FAILED ***");
		$finish;
	end

	// Collects response bytes up to resp_last, mid-cycle
	initial begin : collect_resp
		int len;
		len = 0;
		forever begin
			@(negedge clk);
			if (!rst && resp_valid) begin
				got_data.push_back(resp_data);
				len++;
				if (resp_last) begin
					got_len.push_back(len);
					len = 0;
				end
			end
		end
	end

	initial begin : compare_resp
		int         n;
		int         m;
		int         i;
		logic [7:0] g;
		logic [7:0] e;
		forever begin
			@(posedge clk);
			if (got_len.size() > 0) begin
				n = got_len.pop_front();
				if (exp_len.size() == 0) begin
					$display("Response of %0d bytes arrived with none expected in test %s",
						n, test_name);
					errors++;
					for (i = 0; i < n; i++) begin
						g = got_data.pop_front();
					end
				end else begin
					m = exp_len.pop_front();
					check_value("resp_len", 32'(n), 32'(m));
					for (i = 0; i < n; i++) begin
						g = got_data.pop_front();
						if (i < m) begin
							e = exp_data.pop_front();
							check_value("resp_data", 32'(g), 32'(e));
						end
					end
					for (i = n; i < m; i++) begin
						e = exp_data.pop_front();
					end
					checked++;
				end
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	function automatic logic [23:0] rand_pins();
		return 24'($random(seed));
	endfunction

	task automatic check_regs();
		check_value("i2c_speed", 32'(i2c_speed), 32'(m_speed));
		check_value("i2c_addr", 32'(i2c_addr), 32'(m_addr));
		check_value("gpio_level", 32'(gpio_level), 32'(m_level));
		check_value("gpio_direction", 32'(gpio_direction), 32'(m_dir));
		check_value("gpio_int_enable", 32'(gpio_int_enable), 32'(m_int));
	endtask

	// Frame bytes right-aligned in fr go out with random gaps
	task automatic send_frame(input logic [63:0] fr, input int n);
		int cnt;
		int i;
		int gap;
		int waited;
		cnt = model_frame(fr, n, gpio_read);
		if (cnt > 0) begin
			for (i = 0; i < cnt; i++) begin
				exp_data.push_back(m_resp[i]);
			end
			exp_len.push_back(cnt);
			sent_resp++;
		end
		in_frame = 1'b1;
		for (i = 0; i < n; i++) begin
			in_data = fr[8*(n-1-i) +: 8];
			in_valid = 1'b1;
			step();
			in_valid = 1'b0;
			gap = {$random(seed)} % 3;
			repeat (gap) begin
				step();
			end
		end
		in_frame = 1'b0;
		waited = 0;
		while (checked < sent_resp && waited < RESP_WAIT) begin
			step();
			waited++;
		end
		if (checked < sent_resp) begin
			$display("No response to command 0x%02h in test %s", fr[8*(n-1) +: 8], test_name);
			errors++;
			exp_len.delete();
			exp_data.delete();
			sent_resp = checked;
		end
		// Long enough for a stray response or a late commit to show
		repeat (8) begin
			step();
		end
		check_regs();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_base = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_err_base) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - test_err_base);
			tests_bad++;
		end
	endtask

	task automatic test_version();
		begin_test("version");
		send_frame(64'({8'h76, rand_byte(), 8'h02, 8'h00, 8'h04}), 5);
		send_frame(64'({8'h76, rand_byte(), 8'h02, 8'h00, 8'h05}), 5);
		send_frame(64'({8'h76, rand_byte(), 8'h02, 8'h01, 8'h04}), 5);
		end_test();
	endtask

	task automatic test_i2c();
		begin_test("i2c");
		check_regs();
		send_frame(64'({8'h49, rand_byte(), 8'h01, "c"}), 4);
		send_frame(64'({8'h49, rand_byte(), 8'h01, "a"}), 4);
		repeat (3) begin
			send_frame(64'({8'h69, rand_byte(), 8'h02, "c", rand_byte()}), 5);
			send_frame(64'({8'h69, rand_byte(), 8'h03, "a", rand_byte(), rand_byte()}), 6);
			send_frame(64'({8'h49, rand_byte(), 8'h01, "c"}), 4);
			send_frame(64'({8'h49, rand_byte(), 8'h01, "a"}), 4);
		end
		end_test();
	endtask

	task automatic test_gpio();
		begin_test("gpio");
		gpio_read = rand_pins();
		send_frame(64'({8'h47, rand_byte(), 8'h01, "l"}), 4);
		repeat (2) begin
			send_frame(64'({8'h67, rand_byte(), 8'h04, "l", rand_pins()}), 7);
			send_frame(64'({8'h67, rand_byte(), 8'h04, "d", rand_pins()}), 7);
			send_frame(64'({8'h67, rand_byte(), 8'h04, "i", rand_pins()}), 7);
			gpio_read = rand_pins();
			send_frame(64'({8'h47, rand_byte(), 8'h01, "l"}), 4);
			send_frame(64'({8'h47, rand_byte(), 8'h01, "d"}), 4);
			send_frame(64'({8'h47, rand_byte(), 8'h01, "i"}), 4);
		end
		end_test();
	endtask

	task automatic test_unknown();
		begin_test("unknown");
		send_frame(64'({8'h5A, rand_byte(), 8'h01, "c"}), 4);
		send_frame(64'({8'h47, rand_byte(), 8'h01, "z"}), 4);
		send_frame(64'({8'h49, rand_byte(), 8'h01, "d"}), 4);
		send_frame(64'({8'h69, rand_byte(), 8'h02, "l", rand_byte()}), 5);
		end_test();
	endtask

	task automatic test_truncated();
		begin_test("truncated");
		send_frame(64'({8'h67, rand_byte(), 8'h04, "d", rand_byte(), rand_byte()}), 6);
		send_frame(64'({8'h47, rand_byte(), 8'h01, "d"}), 4);
		send_frame(64'({8'h67, rand_byte(), 8'h04, "d", rand_pins()}), 7);
		send_frame(64'({8'h47, rand_byte(), 8'h01, "d"}), 4);
		end_test();
	endtask

	initial begin
		seed = 31;
		rst = 1'b1;
		in_data = 8'h00;
		in_valid = 1'b0;
		in_frame = 1'b0;
		gpio_read = 24'h000000;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		sent_resp = 0;
		checked = 0;
		test_name = "reset";
		model_reset();
		repeat (5) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
		repeat (2) begin
			step();
		end
		test_version();
		test_i2c();
		test_gpio();
		test_unknown();
		test_truncated();
		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verif
verilog/ice_pkg.sv
verilog/frame_rx.sv
verilog/cmd_ctrl.sv
verilog/param_regs.sv
verilog/resp_tx.sv
verilog/ice_basics.sv
verif/tb_ice_basics.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -f verilog.f --top-module tb_ice_basics -o sim_ice
./obj_dir/sim_ice > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
